// ==== Bender.yml ====
package:
  name: tlb

sources:
  - include_dirs:
      - src
    files:
      - src/tlb_entry_pkg.sv
      - src/tlb_port_pkg.sv
      - src/tlb_entry_array.sv
      - src/tlb_search_port.sv
      - src/tlb_top.sv

  - target: simulation
    include_dirs:
      - src
      - sim
    files:
      - sim/tlb_tb.sv

// ==== project.f ====
+incdir+src
+incdir+sim
src/tlb_entry_pkg.sv
src/tlb_port_pkg.sv
src/tlb_entry_array.sv
src/tlb_search_port.sv
src/tlb_top.sv
sim/tlb_tb.sv

// ==== sim/tlb_tb_table.svh ====
`ifndef TLB_TB_TABLE_SVH
`define TLB_TB_TABLE_SVH

// read_row         name, index
// write_row        name, index, vpn2, asid, g
// write_search_row name, index, vpn2, asid, g, s0 vpn2, s0 asid, s0 odd, found, hit index
// search_row       name, vpn2, asid, odd, found, hit index (same key on both ports)
// dual_row         name, s0 vpn2, asid, odd, found, index, s1 vpn2, asid, odd, found, index

////////////////////
// reset clearing
////////////////////

read_row("reset_read_0", 0);
read_row("reset_read_7", 7);
read_row("reset_read_15", 15);

////////////////////
// fill, entries 5 and 12 global
////////////////////

write_row("fill_0", 0, 19'h01000, 8'h20, 1'b0);
write_row("fill_1", 1, 19'h01001, 8'h21, 1'b0);
write_row("fill_2", 2, 19'h01002, 8'h22, 1'b0);
write_row("fill_3", 3, 19'h01003, 8'h23, 1'b0);
write_row("fill_4", 4, 19'h01004, 8'h24, 1'b0);
write_row("fill_5", 5, 19'h01005, 8'h25, 1'b1);
write_row("fill_6", 6, 19'h01006, 8'h26, 1'b0);
write_row("fill_7", 7, 19'h01007, 8'h27, 1'b0);
write_row("fill_8", 8, 19'h01008, 8'h28, 1'b0);
write_row("fill_9", 9, 19'h01009, 8'h29, 1'b0);
write_row("fill_10", 10, 19'h0100a, 8'h2a, 1'b0);
write_row("fill_11", 11, 19'h0100b, 8'h2b, 1'b0);
write_row("fill_12", 12, 19'h0100c, 8'h2c, 1'b1);
write_row("fill_13", 13, 19'h0100d, 8'h2d, 1'b0);
write_row("fill_14", 14, 19'h0100e, 8'h2e, 1'b0);
write_row("fill_15", 15, 19'h0100f, 8'h2f, 1'b0);

// read back every index
for (int i = 0; i < `TLB_NUM; i++) begin
    read_row($sformatf("readback_%0d", i), i);
end

////////////////////
// search
////////////////////

search_row("hit_even_3", 19'h01003, 8'h23, 1'b0, 1'b1, 3);
search_row("hit_odd_3", 19'h01003, 8'h23, 1'b1, 1'b1, 3);
search_row("hit_even_15", 19'h0100f, 8'h2f, 1'b0, 1'b1, 15);
search_row("hit_odd_0", 19'h01000, 8'h20, 1'b1, 1'b1, 0);
search_row("global_any_asid_5", 19'h01005, 8'hff, 1'b1, 1'b1, 5);
search_row("global_any_asid_12", 19'h0100c, 8'h00, 1'b0, 1'b1, 12);
search_row("asid_miss_3", 19'h01003, 8'h24, 1'b0, 1'b0, 0);
search_row("vpn2_miss", 19'h02000, 8'h20, 1'b1, 1'b0, 0);

// ports searched independently in one cycle
dual_row("dual_hit_hit", 19'h01001, 8'h21, 1'b0, 1'b1, 1, 19'h01009, 8'h29, 1'b1, 1'b1, 9);
dual_row("dual_hit_miss", 19'h0100a, 8'h2a, 1'b1, 1'b1, 10, 19'h0100b, 8'h00, 1'b0, 1'b0, 0);

////////////////////
// overwrite
////////////////////

// old vpn2 still hits during the write cycle
write_search_row("overwrite_7", 7, 19'h03007, 8'h27, 1'b0, 19'h01007, 8'h27, 1'b0, 1'b1, 7);
search_row("overwrite_old_miss_7", 19'h01007, 8'h27, 1'b0, 1'b0, 0);
search_row("overwrite_new_hit_7", 19'h03007, 8'h27, 1'b1, 1'b1, 7);
read_row("overwrite_read_7", 7);
// new vpn2 not yet visible during the write cycle
write_search_row("overwrite_12", 12, 19'h0300c, 8'h00, 1'b1, 19'h0300c, 8'h55, 1'b0, 1'b0, 0);
search_row("overwrite_new_hit_12", 19'h0300c, 8'h55, 1'b0, 1'b1, 12);
read_row("overwrite_read_12", 12);

`endif

// ==== sim/tlb_tb.sv ====
`timescale 1ns/10ps

`include "tlb_settings.svh"

module tlb_tb;

    import tlb_entry_pkg::*;
    import tlb_port_pkg::*;

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 5;
    localparam int RESET_TIMEOUT = 50;
    localparam logic [31:0] SEED = 32'h06eeb2a1;

    // key that matches no written entry
    localparam tlb_search_req_t IDLE_KEY = '{vpn2: '1, odd_page: 1'b0, asid: '1};

    typedef enum logic [1:0] {OP_WRITE, OP_SEARCH, OP_READ} op_e;

    typedef struct {
        string           name;
        op_e             op;
        tlb_index_t      index;
        tlb_vpn2_t       w_vpn2;
        tlb_asid_t       w_asid;
        logic            w_g;
        tlb_search_req_t key0;
        tlb_search_req_t key1;
        logic            chk0;
        logic            chk1;
        logic            exp_found0;
        logic            exp_found1;
        tlb_index_t      exp_index0;
        tlb_index_t      exp_index1;
    } row_t;

    logic            clk;
    logic            reset;
    tlb_search_req_t s0_req;
    tlb_search_req_t s1_req;
    tlb_search_res_t s0_res;
    tlb_search_res_t s1_res;
    tlb_write_req_t  wr;
    tlb_index_t      r_index;
    tlb_entry_t      r_entry;

    // reference copy of the table
    tlb_entry_t model [`TLB_NUM];
    row_t       rows [$];

    tlb_top dut0 (
        .clk     (clk),
        .reset   (reset),
        .s0_req  (s0_req),
        .s0_res  (s0_res),
        .s1_req  (s1_req),
        .s1_res  (s1_res),
        .wr      (wr),
        .r_index (r_index),
        .r_entry (r_entry)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

    ////////////////////
    // table rows
    ////////////////////

    function automatic row_t blank_row(input string name, input op_e op);
        row_t r;
        r.name = name;
        r.op = op;
        r.index = '0;
        r.w_vpn2 = '0;
        r.w_asid = '0;
        r.w_g = 1'b0;
        r.key0 = IDLE_KEY;
        r.key1 = IDLE_KEY;
        r.chk0 = 1'b0;
        r.chk1 = 1'b0;
        r.exp_found0 = 1'b0;
        r.exp_found1 = 1'b0;
        r.exp_index0 = '0;
        r.exp_index1 = '0;
        return r;
    endfunction

    task automatic read_row(input string name, input int idx);
        row_t r;
        r = blank_row(name, OP_READ);
        r.index = tlb_index_t'(idx);
        rows.push_back(r);
    endtask

    task automatic write_search_row(input string name, input int idx, input tlb_vpn2_t vpn2,
                                    input tlb_asid_t asid, input logic g,
                                    input tlb_vpn2_t s_vpn2, input tlb_asid_t s_asid,
                                    input logic s_odd, input logic found, input int s_idx);
        row_t r;
        r = blank_row(name, OP_WRITE);
        r.index = tlb_index_t'(idx);
        r.w_vpn2 = vpn2;
        r.w_asid = asid;
        r.w_g = g;
        r.key0 = '{vpn2: s_vpn2, odd_page: s_odd, asid: s_asid};
        r.chk0 = 1'b1;
        r.exp_found0 = found;
        r.exp_index0 = tlb_index_t'(s_idx);
        rows.push_back(r);
    endtask

    task automatic write_row(input string name, input int idx, input tlb_vpn2_t vpn2,
                             input tlb_asid_t asid, input logic g);
        write_search_row(name, idx, vpn2, asid, g, '1, '1, 1'b0, 1'b0, 0);
        // no search check while filling
        rows[$].chk0 = 1'b0;
    endtask

    task automatic dual_row(input string name,
                            input tlb_vpn2_t v0, input tlb_asid_t a0, input logic o0,
                            input logic f0, input int i0,
                            input tlb_vpn2_t v1, input tlb_asid_t a1, input logic o1,
                            input logic f1, input int i1);
        row_t r;
        r = blank_row(name, OP_SEARCH);
        r.key0 = '{vpn2: v0, odd_page: o0, asid: a0};
        r.key1 = '{vpn2: v1, odd_page: o1, asid: a1};
        r.chk0 = 1'b1;
        r.chk1 = 1'b1;
        r.exp_found0 = f0;
        r.exp_found1 = f1;
        r.exp_index0 = tlb_index_t'(i0);
        r.exp_index1 = tlb_index_t'(i1);
        rows.push_back(r);
    endtask

    task automatic search_row(input string name, input tlb_vpn2_t vpn2, input tlb_asid_t asid,
                              input logic odd, input logic found, input int idx);
        dual_row(name, vpn2, asid, odd, found, idx, vpn2, asid, odd, found, idx);
    endtask

    task automatic build_table();
        `include "tlb_tb_table.svh"
    endtask

    ////////////////////
    // checks
    ////////////////////

    task automatic check_equal(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s expected %0h actual %0h", name, expected, actual);
            $display("Verification failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    // page expected from the model, all zero on a miss
    task automatic check_search(input string name, input tlb_search_res_t res,
                                input logic found, input tlb_index_t idx, input logic odd);
        tlb_page_t page;
        page = '0;
        if (found) begin
            page = odd ? model[idx].page1 : model[idx].page0;
        end
        check_equal({name, " found"}, found, res.found);
        check_equal({name, " index"}, idx, res.index);
        check_equal({name, " page"}, page, res.page);
    endtask

    function automatic tlb_page_t random_page();
        tlb_page_t p;
        p.pfn = tlb_pfn_t'($urandom);
        p.c = tlb_cattr_t'($urandom);
        p.d = 1'($urandom);
        p.v = 1'($urandom);
        return p;
    endfunction

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (reset === 1'b1 && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (reset !== 1'b0) begin
            $display("timeout, reset never released after %0d cycles", cycles);
            $display("Verification failed");
            $fatal(1, "reset timeout");
        end
    endtask

    ////////////////////
    // row loop
    ////////////////////

    // drive on the falling edge, sample in the low phase
    task automatic apply_row(input row_t r);
        tlb_entry_t new_entry;
        @(negedge clk);
        new_entry = '0;
        wr = '0;
        if (r.op == OP_WRITE) begin
            new_entry.vpn2 = r.w_vpn2;
            new_entry.asid = r.w_asid;
            new_entry.g = r.w_g;
            new_entry.page0 = random_page();
            new_entry.page1 = random_page();
            wr.we = 1'b1;
            wr.index = r.index;
            wr.entry = new_entry;
        end
        s0_req = r.key0;
        s1_req = r.key1;
        r_index = r.index;
        #(CLK_PERIOD / 4);
        if (r.chk0) begin
            check_search({r.name, " s0"}, s0_res, r.exp_found0, r.exp_index0, r.key0.odd_page);
        end
        if (r.chk1) begin
            check_search({r.name, " s1"}, s1_res, r.exp_found1, r.exp_index1, r.key1.odd_page);
        end
        if (r.op == OP_READ) begin
            check_equal({r.name, " entry"}, model[r.index], r_entry);
        end
        // write takes effect at this edge
        @(posedge clk);
        if (r.op == OP_WRITE) begin
            model[r.index] = new_entry;
        end
    endtask

    initial begin
        void'($urandom(SEED));
        s0_req = IDLE_KEY;
        s1_req = IDLE_KEY;
        wr = '0;
        r_index = '0;
        for (int i = 0; i < `TLB_NUM; i++) begin
            model[i] = '0;
        end
        build_table();
        wait_reset_release();
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        @(negedge clk);
        wr = '0;
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== src/tlb_entry_array.sv ====
`timescale 1ns/10ps

`include "tlb_settings.svh"

module tlb_entry_array (
    input  logic                           clk,
    input  logic                           reset,

    // write port
    input  tlb_port_pkg::tlb_write_req_t   wr,

    // read port
    input  tlb_entry_pkg::tlb_index_t      r_index,
    output tlb_entry_pkg::tlb_entry_t      r_entry,

    // full table to the search ports
    output tlb_entry_pkg::tlb_entry_vec_t  entries
);

    import tlb_entry_pkg::*;

    ////////////////////
    // storage
    ////////////////////

    // all entries, held as flops so both
    // search ports see every entry at once
    tlb_entry_vec_t entry_q;

    ////////////////////
    // write
    ////////////////////

    // reset clears every entry, so g and v come up low
    // and a search after reset only matches vpn2 zero
    // with asid zero, reporting v low
    always_ff @(posedge clk) begin
        if (reset) begin
            entry_q <= '0;
        end else if (wr.we) begin
            // whole entry replaced, both pages together
            entry_q[wr.index] <= wr.entry;
        end
    end

    ////////////////////
    // read
    ////////////////////

    // combinational, reflects the last clock edge
    assign r_entry = entry_q[r_index];

    // same contents for the search side
    // a write in this cycle is not yet visible
    assign entries = entry_q;

    ////////////////////
    // checks
    ////////////////////

    // the index must name a real slot when the
    // entry count is not a power of two
    wr_index_in_range: assert property (
        @(posedge clk) disable iff (reset)
        wr.we |-> (int'(wr.index) < `TLB_NUM)
    ) else $error("tlb write to index %0d outside table", wr.index);

endmodule

// ==== src/tlb_entry_pkg.sv ====
`include "tlb_settings.svh"

package tlb_entry_pkg;

    ////////////////////
    // field types
    ////////////////////

    // entry index, one of TLB_NUM slots
    typedef logic [$clog2(`TLB_NUM)-1:0] tlb_index_t;

    typedef logic [`TLB_VPN2_W-1:0] tlb_vpn2_t;
    typedef logic [`TLB_ASID_W-1:0] tlb_asid_t;
    typedef logic [`TLB_PFN_W-1:0] tlb_pfn_t;
    typedef logic [`TLB_C_W-1:0] tlb_cattr_t;

    ////////////////////
    // page and entry
    ////////////////////

    // one page of a pair
    typedef struct packed {
        tlb_pfn_t pfn;
        tlb_cattr_t c;
        logic d;
        logic v;
    } tlb_page_t;

    // one entry maps an even/odd page pair
    typedef struct packed {
        tlb_vpn2_t vpn2;
        tlb_asid_t asid;
        // global, asid ignored on compare
        logic g;
        // even page, vaddr bit 12 low
        tlb_page_t page0;
        // odd page
        tlb_page_t page1;
    } tlb_entry_t;

    // whole table, entry i at index i
    typedef tlb_entry_t [`TLB_NUM-1:0] tlb_entry_vec_t;

endpackage

// ==== src/tlb_port_pkg.sv ====
`include "tlb_settings.svh"

package tlb_port_pkg;

    ////////////////////
    // search port
    ////////////////////

    // lookup key from the address path
    typedef struct packed {
        tlb_entry_pkg::tlb_vpn2_t vpn2;
        // vaddr bit 12, picks page1 when high
        logic odd_page;
        tlb_entry_pkg::tlb_asid_t asid;
    } tlb_search_req_t;

    // lookup answer
    // on a miss all fields are zero
    typedef struct packed {
        logic found;
        tlb_entry_pkg::tlb_index_t index;
        // v is reported, not checked
        tlb_entry_pkg::tlb_page_t page;
    } tlb_search_res_t;

    ////////////////////
    // write port
    ////////////////////

    // single-cycle strobe, whole entry at once
    typedef struct packed {
        logic we;
        tlb_entry_pkg::tlb_index_t index;
        tlb_entry_pkg::tlb_entry_t entry;
    } tlb_write_req_t;

    // widths seen at the top level
    // search req 28, search res 30, write req 83
    // the entry alone is 78
    //
    // software keeps entries unique
    // so at most one match per search
    //
    // no handshake on any port

endpackage

// ==== src/tlb_search_port.sv ====
`timescale 1ns/10ps

`include "tlb_settings.svh"

module tlb_search_port (
    // clock and reset only sample the check below
    input  logic                           clk,
    input  logic                           reset,

    // table contents from the entry array
    input  tlb_entry_pkg::tlb_entry_vec_t  entries,

    // lookup key and answer
    input  tlb_port_pkg::tlb_search_req_t  req,
    output tlb_port_pkg::tlb_search_res_t  res
);

    import tlb_entry_pkg::*;

    ////////////////////
    // compare
    ////////////////////

    // one bit per entry
    logic [`TLB_NUM-1:0] match;

    // vpn2 must be equal, asid equal unless the entry is global
    // valid bits play no part here, they go out with the page
    always_comb begin
        for (int i = 0; i < `TLB_NUM; i++) begin
            match[i] = (req.vpn2 == entries[i].vpn2)
                    && ((req.asid == entries[i].asid) || entries[i].g);
        end
    end

    ////////////////////
    // encode and select
    ////////////////////

    tlb_index_t hit_index;
    tlb_page_t  hit_page;

    // match is one-hot or zero, so an OR over the
    // masked indices gives the encoded position and
    // an AND-OR over the pages gives the hit page
    //
    // all zero on a miss, no extra gating needed
    always_comb begin
        tlb_page_t cand;
        hit_index = '0;
        hit_page  = '0;
        for (int i = 0; i < `TLB_NUM; i++) begin
            // even or odd half of the pair
            cand = req.odd_page ? entries[i].page1 : entries[i].page0;
            if (match[i]) begin
                hit_index = hit_index | tlb_index_t'(i);
            end
            hit_page = hit_page | ({$bits(tlb_page_t){match[i]}} & cand);
        end
    end

    ////////////////////
    // result
    ////////////////////

    // any match is a hit
    assign res.found = |match;
    assign res.index = hit_index;
    assign res.page  = hit_page;

    ////////////////////
    // checks
    ////////////////////

    // duplicate entries in the table would make the
    // encoded index and page a blend of several entries
    single_match: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(match)
    ) else $error("tlb search hit several entries, match %b", match);

endmodule

// ==== src/tlb_settings.svh ====
`ifndef TLB_SETTINGS_SVH
`define TLB_SETTINGS_SVH

////////////////////
// table geometry
////////////////////

// number of entries, fully associative
`define TLB_NUM 16

////////////////////
// field widths
////////////////////

// virtual page pair number, vaddr bits 31..13
`define TLB_VPN2_W 19
`define TLB_ASID_W 8
// physical frame number of one page
`define TLB_PFN_W 20
`define TLB_C_W 3

`endif

// ==== src/tlb_top.sv ====
`timescale 1ns/10ps

module tlb_top (
    input  logic                           clk,
    input  logic                           reset,

    // search port 0
    input  tlb_port_pkg::tlb_search_req_t  s0_req,
    output tlb_port_pkg::tlb_search_res_t  s0_res,

    // search port 1
    input  tlb_port_pkg::tlb_search_req_t  s1_req,
    output tlb_port_pkg::tlb_search_res_t  s1_res,

    // write port
    input  tlb_port_pkg::tlb_write_req_t   wr,

    // read port
    input  tlb_entry_pkg::tlb_index_t      r_index,
    output tlb_entry_pkg::tlb_entry_t      r_entry
);

    import tlb_entry_pkg::*;

    ////////////////////
    // table
    ////////////////////

    // full table, shared by both search ports
    tlb_entry_vec_t entries;

    tlb_entry_array entries0 (
        .clk     (clk),
        .reset   (reset),
        .wr      (wr),
        .r_index (r_index),
        .r_entry (r_entry),
        .entries (entries)
    );

    ////////////////////
    // search ports
    ////////////////////

    // instruction side lookup
    tlb_search_port search0 (
        .clk     (clk),
        .reset   (reset),
        .entries (entries),
        .req     (s0_req),
        .res     (s0_res)
    );

    // data side lookup, independent of port 0
    tlb_search_port search1 (
        .clk     (clk),
        .reset   (reset),
        .entries (entries),
        .req     (s1_req),
        .res     (s1_res)
    );

endmodule
